// File: cpu_pkg.sv
package cpu_pkg;

  localparam int word_w = 16;            // data and address width
  localparam int reg_count = 32;         // size of the register file
  localparam int ram_words = 700;        // memory depth in words
  localparam int ram_aw = $clog2(ram_words);  // index bits into the memory
  localparam int address_program = 52;   // first word of program and data area

  typedef logic [word_w-1:0] word_t;     // one memory or register word
  typedef logic [4:0] reg_idx_t;         // register number
  typedef logic [2:0] cnt_t;             // count-minus-one and element index

  // high byte of the first instruction word
  typedef enum logic [7:0] {
    op_ram2reg   = 8'h09,  // memory block -> registers
    op_reg2ram   = 8'h0e,  // registers -> memory block
    op_num2reg   = 8'h12,  // constant -> registers
    op_reg_plus  = 8'h14,  // reg += value
    op_reg_minus = 8'h15,  // reg -= value
    op_reg_mul   = 8'h16,  // reg *= value, low half kept
    op_exit      = 8'h18   // stop the program
  } opcode_e;

  // codes are the same numbers the host already knows
  typedef enum logic [3:0] {
    err_none          = 4'd0,
    err_wrong_address = 4'd1,  // operand block outside program area
    err_wrong_reg_num = 4'd3,  // base+count past last register
    err_wrong_opcode  = 4'd4   // nothing we decode
  } error_e;

  typedef enum logic [1:0] {
    st_idle,   // waiting for start, host owns memory
    st_fetch,  // reading the word pair at pc
    st_exec    // one element per cycle
  } seq_state_e;

endpackage

// File: instr_if.sv
interface instr_if;

  logic                 valid;     // one element in flight this cycle
  logic [7:0]           opcode;    // raw high byte, may be undecodable
  cpu_pkg::reg_idx_t    reg_base;  // first register of the group
  cpu_pkg::cnt_t        count;     // elements minus one
  cpu_pkg::word_t       operand;   // value or start address
  cpu_pkg::cnt_t        elem;      // index of the current element

  // sequencer owns every field
  modport seq (
    output valid, opcode, reg_base, count, operand, elem
  );

  // range check only needs the static part of the instruction
  modport check (
    input opcode, reg_base, count, operand
  );

  modport exec (
    input opcode, reg_base, operand, elem
  );

  modport retire (
    input valid, opcode
  );

endinterface

// File: program_ram.sv
module program_ram (
  input  logic           clk,
  input  logic           busy,        // core owns the memory
  input  logic           host_we,
  input  cpu_pkg::word_t host_addr,
  input  cpu_pkg::word_t host_wdata,
  input  cpu_pkg::word_t rd_addr_a,
  input  cpu_pkg::word_t rd_addr_b,
  input  logic           mem_we,
  input  cpu_pkg::word_t mem_addr,
  input  cpu_pkg::word_t mem_wdata,
  output cpu_pkg::word_t rd_data_a,
  output cpu_pkg::word_t rd_data_b,
  output cpu_pkg::word_t host_rdata
);

  cpu_pkg::word_t mem [cpu_pkg::ram_words];  // program and data share one array

  cpu_pkg::word_t addr_a;    // port a after host/core select
  cpu_pkg::word_t wr_addr;
  cpu_pkg::word_t wr_data;
  logic           wr_en;

  assign addr_a = busy ? rd_addr_a : host_addr;  // idle -> host reads through port a

  // both read ports are asynchronous
  assign rd_data_a  = mem[addr_a[cpu_pkg::ram_aw-1:0]];
  assign rd_data_b  = mem[rd_addr_b[cpu_pkg::ram_aw-1:0]];
  assign host_rdata = rd_data_a;  // valid while idle only

  // host writes are dropped while the core runs
  assign wr_en   = busy ? mem_we : host_we;
  assign wr_addr = busy ? mem_addr : host_addr;
  assign wr_data = busy ? mem_wdata : host_wdata;

  always_ff @(posedge clk) begin
    if (wr_en && wr_addr < cpu_pkg::word_t'(cpu_pkg::ram_words)) begin  // ignore past 699
      mem[wr_addr[cpu_pkg::ram_aw-1:0]] <= wr_data;
    end
  end

endmodule

// File: seq_ctrl.sv
module seq_ctrl (
  input  logic           clk,
  input  logic           rst,
  input  logic           start,      // pulse, honoured only when idle
  input  cpu_pkg::word_t rd_data_a,  // first word of the pair
  input  cpu_pkg::word_t rd_data_b,  // value or address word
  input  logic           halt,       // exit or error seen this element
  output cpu_pkg::word_t rd_addr_a,
  output cpu_pkg::word_t rd_addr_b,
  output logic           busy,
  output logic           halted,
  instr_if.seq           ibus
);

  cpu_pkg::seq_state_e state;
  cpu_pkg::word_t      pc;          // address of the current word pair
  cpu_pkg::cnt_t       elem_q;      // element being issued
  cpu_pkg::word_t      instr_word;  // opcode, count, base
  cpu_pkg::word_t      operand_q;
  logic                last_elem;

  assign busy = state != cpu_pkg::st_idle;

  // fetch reads pc and pc+1 in one cycle
  assign rd_addr_a = pc;
  assign rd_addr_b = pc + 16'd1;

  // split the first word into its fields
  assign ibus.valid    = state == cpu_pkg::st_exec;
  assign ibus.opcode   = instr_word[15:8];
  assign ibus.count    = instr_word[7:5];
  assign ibus.reg_base = instr_word[4:0];
  assign ibus.operand  = operand_q;
  assign ibus.elem     = elem_q;

  assign last_elem = elem_q == instr_word[7:5];

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= cpu_pkg::st_idle;
      pc     <= cpu_pkg::word_t'(cpu_pkg::address_program);
      elem_q <= '0;
      halted <= 1'b0;
    end else begin
      case (state)
        cpu_pkg::st_idle: begin
          if (start) begin
            state  <= cpu_pkg::st_fetch;
            pc     <= cpu_pkg::word_t'(cpu_pkg::address_program);  // always from the top
            halted <= 1'b0;                                         // previous result dropped
          end
        end
        cpu_pkg::st_fetch: begin
          state  <= cpu_pkg::st_exec;  // element 0 issues next cycle
          elem_q <= '0;
        end
        cpu_pkg::st_exec: begin
          if (halt) begin
            state  <= cpu_pkg::st_idle;  // busy falls on this edge
            halted <= 1'b1;
          end else if (last_elem) begin
            state <= cpu_pkg::st_fetch;
            pc    <= pc + 16'd2;          // next word pair
          end else begin
            elem_q <= elem_q + 3'd1;
          end
        end
        default: begin
          state <= cpu_pkg::st_idle;
        end
      endcase
    end
  end

  // word pair is held for the whole instruction
  always_ff @(posedge clk) begin
    if (state == cpu_pkg::st_fetch) begin
      instr_word <= rd_data_a;
      operand_q  <= rd_data_b;
    end
  end

endmodule

// File: instr_check.sv
module instr_check (
  instr_if.check           ibus,
  output cpu_pkg::error_e  err,
  output logic             is_exit
);

  logic [5:0]  last_reg;   // base+count, one bit wider so 32+ is visible
  logic [16:0] last_addr;  // operand+count without wrap
  logic        reg_bad;
  logic        addr_bad;

  assign last_reg  = {1'b0, ibus.reg_base} + 6'(ibus.count);
  assign last_addr = {1'b0, ibus.operand} + 17'(ibus.count);

  assign reg_bad  = last_reg >= 6'(cpu_pkg::reg_count);
  assign addr_bad = ibus.operand < cpu_pkg::word_t'(cpu_pkg::address_program) ||
                    last_addr > 17'(cpu_pkg::ram_words - 1);  // last word beyond 699

  always_comb begin
    err     = cpu_pkg::err_none;
    is_exit = 1'b0;
    case (ibus.opcode)
      cpu_pkg::op_num2reg,
      cpu_pkg::op_reg_plus,
      cpu_pkg::op_reg_minus,
      cpu_pkg::op_reg_mul: begin
        if (reg_bad) err = cpu_pkg::err_wrong_reg_num;
      end
      cpu_pkg::op_ram2reg,
      cpu_pkg::op_reg2ram: begin
        // register range wins over the address range
        if (reg_bad) begin
          err = cpu_pkg::err_wrong_reg_num;
        end else if (addr_bad) begin
          err = cpu_pkg::err_wrong_address;
        end
      end
      cpu_pkg::op_exit: begin
        is_exit = 1'b1;  // no operand checks on exit
      end
      default: begin
        err = cpu_pkg::err_wrong_opcode;
      end
    endcase
  end

endmodule

// File: exec_unit.sv
module exec_unit (
  input  logic           clk,
  input  logic           rst,
  instr_if.exec          ibus,
  input  cpu_pkg::word_t ram_rdata,  // port a data for ram2reg
  input  logic           reg_we,     // committed write of this element
  output cpu_pkg::word_t ram_raddr,
  output cpu_pkg::word_t reg_wdata,
  output cpu_pkg::word_t mem_addr,
  output cpu_pkg::word_t mem_wdata
);

  cpu_pkg::word_t    regs [cpu_pkg::reg_count];
  cpu_pkg::reg_idx_t idx;  // base+elem
  cpu_pkg::word_t    cur;  // register value before the op

  assign idx = ibus.reg_base + cpu_pkg::reg_idx_t'(ibus.elem);
  assign cur = regs[idx];

  // memory address walks with the register
  assign mem_addr  = ibus.operand + cpu_pkg::word_t'(ibus.elem);
  assign ram_raddr = mem_addr;
  assign mem_wdata = cur;  // reg2ram stores the register as is

  always_comb begin
    case (ibus.opcode)
      cpu_pkg::op_num2reg: begin
        reg_wdata = ibus.operand;
      end
      cpu_pkg::op_reg_plus: begin
        reg_wdata = cur + ibus.operand;  // wraps at 16 bits
      end
      cpu_pkg::op_reg_minus: begin
        reg_wdata = cur - ibus.operand;
      end
      cpu_pkg::op_reg_mul: begin
        reg_wdata = cur * ibus.operand;  // low half of the product
      end
      cpu_pkg::op_ram2reg: begin
        reg_wdata = ram_rdata;
      end
      default: begin
        reg_wdata = cur;  // no register change for the rest
      end
    endcase
  end

  // registers survive between runs, only reset clears them
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < cpu_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_we) begin
      regs[idx] <= reg_wdata;
    end
  end

endmodule

// File: retire_unit.sv
module retire_unit (
  input  logic             clk,
  input  logic             rst,
  instr_if.retire          ibus,
  input  cpu_pkg::error_e  err,
  input  logic             is_exit,
  input  logic             start,
  output logic             reg_we,
  output logic             mem_we,
  output logic             halt,
  output cpu_pkg::error_e  error_code
);

  logic writes_reg;  // opcode class with a register result
  logic commit;      // element may write

  always_comb begin
    case (ibus.opcode)
      cpu_pkg::op_num2reg,
      cpu_pkg::op_reg_plus,
      cpu_pkg::op_reg_minus,
      cpu_pkg::op_reg_mul,
      cpu_pkg::op_ram2reg: writes_reg = 1'b1;
      default:             writes_reg = 1'b0;
    endcase
  end

  // a faulting or exiting element writes nothing
  assign commit = ibus.valid && err == cpu_pkg::err_none && !is_exit;

  assign reg_we = commit && writes_reg;
  assign mem_we = commit && ibus.opcode == cpu_pkg::op_reg2ram;
  assign halt   = ibus.valid && (err != cpu_pkg::err_none || is_exit);

  // the code stays until the host starts again
  always_ff @(posedge clk) begin
    if (rst) begin
      error_code <= cpu_pkg::err_none;
    end else if (halt) begin
      error_code <= err;  // err_none on a clean exit
    end else if (start) begin
      error_code <= cpu_pkg::err_none;
    end
  end

endmodule

// File: reg_cpu.sv
module reg_cpu (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  logic            host_we,
  input  cpu_pkg::word_t  host_addr,
  input  cpu_pkg::word_t  host_wdata,
  output cpu_pkg::word_t  host_rdata,
  output logic            busy,
  output logic            halted,
  output cpu_pkg::error_e error_code
);

  instr_if ibus ();  // current element, sequencer -> check/exec/retire

  cpu_pkg::word_t  seq_addr_a;   // fetch address pc
  cpu_pkg::word_t  exec_raddr;   // ram2reg source address
  cpu_pkg::word_t  rd_addr_a;
  cpu_pkg::word_t  rd_addr_b;
  cpu_pkg::word_t  rd_data_a;
  cpu_pkg::word_t  rd_data_b;
  cpu_pkg::word_t  mem_addr;
  cpu_pkg::word_t  mem_wdata;
  cpu_pkg::error_e err;
  logic            is_exit;
  logic            reg_we;
  logic            mem_we;
  logic            halt;

  assign rd_addr_a = ibus.valid ? exec_raddr : seq_addr_a;  // elements read port a

  program_ram i_program_ram (
    .clk(clk), .busy(busy), .host_we(host_we), .host_addr(host_addr),
    .host_wdata(host_wdata), .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
    .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .host_rdata(host_rdata)
  );

  seq_ctrl i_seq_ctrl (
    .clk(clk), .rst(rst), .start(start), .rd_data_a(rd_data_a),
    .rd_data_b(rd_data_b), .halt(halt), .rd_addr_a(seq_addr_a),
    .rd_addr_b(rd_addr_b), .busy(busy), .halted(halted), .ibus(ibus.seq)
  );

  instr_check i_instr_check (
    .ibus(ibus.check), .err(err), .is_exit(is_exit)
  );

  exec_unit i_exec_unit (
    .clk(clk), .rst(rst), .ibus(ibus.exec), .ram_rdata(rd_data_a),
    .reg_we(reg_we), .ram_raddr(exec_raddr), .reg_wdata(),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata)
  );

  retire_unit i_retire_unit (
    .clk(clk), .rst(rst), .ibus(ibus.retire), .err(err), .is_exit(is_exit),
    .start(start), .reg_we(reg_we), .mem_we(mem_we), .halt(halt),
    .error_code(error_code)
  );

endmodule

// File: reg_cpu_chk.sv
module reg_cpu_chk (
  input logic            clk,
  input logic            rst,
  input logic            busy,
  input logic            halted,
  input logic            host_we,
  input cpu_pkg::word_t  host_addr,
  input cpu_pkg::word_t  host_word,    // memory word at host_addr
  input logic            mem_we,
  input cpu_pkg::word_t  mem_addr,
  input logic            halt,
  input logic            is_exit,
  input cpu_pkg::error_e error_code
);
  timeunit 1ns;
  timeprecision 1ps;

  // host strobe while running leaves the addressed word as it was
  host_write_blocked: assert property (@(posedge clk) disable iff (rst)
    $past(busy && host_we && !(mem_we && mem_addr == host_addr)) &&
    host_addr == $past(host_addr) |-> host_word == $past(host_word))
    else $error("host write changed the memory while the core was busy");

  busy_halted_apart: assert property (@(posedge clk) disable iff (rst)
    !(busy && halted))
    else $error("busy and halted high in the same cycle");

  // clean exit leaves no error code behind
  exit_code_clean: assert property (@(posedge clk) disable iff (rst)
    halt && is_exit |=> halted && error_code == cpu_pkg::err_none)
    else $error("exit halted with a non-zero error code");

endmodule

bind reg_cpu reg_cpu_chk i_reg_cpu_chk (
  .clk(clk), .rst(rst), .busy(busy), .halted(halted), .host_we(host_we),
  .host_addr(host_addr),
  .host_word(i_program_ram.mem[host_addr[cpu_pkg::ram_aw-1:0]]),
  .mem_we(mem_we), .mem_addr(mem_addr), .halt(halt), .is_exit(is_exit),
  .error_code(error_code)
);

// File: reg_cpu_tb.sv
module reg_cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period = 40;
  localparam int n_tests = 28;        // directed runs plus twenty random programs
  localparam int test_cycles = 200;   // load, run and read-back of one test
  localparam int timeout_ns = (10 + cpu_pkg::ram_words + n_tests * test_cycles) * clk_period;
  localparam int view_base = 32;      // words below the program area, must never change
  localparam int view_lo = 400;       // data area checked after every run
  localparam int view_mid = 464;
  localparam int view_top = 690;      // last words, for blocks running past the end

  logic            clk = 1'b0;
  logic            rst;
  logic            start;
  logic            host_we;
  cpu_pkg::word_t  host_addr;
  cpu_pkg::word_t  host_wdata;
  cpu_pkg::word_t  host_rdata;
  logic            busy;
  logic            halted;
  cpu_pkg::error_e error_code;

  cpu_pkg::word_t  cmp_addr = '0;     // read-back address of the compare process
  cpu_pkg::word_t  dut_addr;
  int              cmp_req = 0;       // bumped by the main sequence
  int              cmp_done = 0;      // caught up by the compare process
  int              mem_errors = 0;
  int              code_errors = 0;
  int              status_errors = 0;
  int              seed = 8267;

  cpu_pkg::word_t  model_mem [cpu_pkg::ram_words];  // shadow of the DUT memory
  cpu_pkg::word_t  model_regs [cpu_pkg::reg_count] = '{default: '0};
  cpu_pkg::word_t  prog [$];                        // program being built
  cpu_pkg::error_e exp_err;

  assign dut_addr = (cmp_req != cmp_done) ? cmp_addr : host_addr;  // compare owns the port

  always #(clk_period / 2) clk = ~clk;

  reg_cpu i_reg_cpu (
    .clk(clk), .rst(rst), .start(start), .host_we(host_we), .host_addr(dut_addr),
    .host_wdata(host_wdata), .host_rdata(host_rdata), .busy(busy), .halted(halted),
    .error_code(error_code)
  );

  // interprets the program at address_program the way the machine should
  function automatic cpu_pkg::error_e run_model();
    int         pc;
    int         cnt;
    int         base;
    int         val;
    int         r;
    logic [7:0] op;
    pc = cpu_pkg::address_program;
    while (pc < cpu_pkg::ram_words - 1) begin
      op   = model_mem[pc][15:8];
      cnt  = int'(model_mem[pc][7:5]);
      base = int'(model_mem[pc][4:0]);
      val  = int'(model_mem[pc + 1]);
      if (op == cpu_pkg::op_exit) return cpu_pkg::err_none;
      if (!(op inside {cpu_pkg::op_num2reg, cpu_pkg::op_reg_plus, cpu_pkg::op_reg_minus,
                       cpu_pkg::op_reg_mul, cpu_pkg::op_ram2reg, cpu_pkg::op_reg2ram}))
        return cpu_pkg::err_wrong_opcode;
      if (base + cnt >= cpu_pkg::reg_count) return cpu_pkg::err_wrong_reg_num;
      if ((op == cpu_pkg::op_ram2reg || op == cpu_pkg::op_reg2ram) &&
          (val < cpu_pkg::address_program || val + cnt > cpu_pkg::ram_words - 1))
        return cpu_pkg::err_wrong_address;
      for (int e = 0; e <= cnt; e++) begin
        r = base + e;
        case (op)
          cpu_pkg::op_num2reg:   model_regs[r] = 16'(val);
          cpu_pkg::op_reg_plus:  model_regs[r] = model_regs[r] + 16'(val);  // 16-bit wrap
          cpu_pkg::op_reg_minus: model_regs[r] = model_regs[r] - 16'(val);
          cpu_pkg::op_reg_mul:   model_regs[r] = model_regs[r] * 16'(val);  // low half
          cpu_pkg::op_ram2reg:   model_regs[r] = model_mem[val + e];
          default:               model_mem[val + e] = model_regs[r];        // reg2ram
        endcase
      end
      pc = pc + 2;
    end
    return cpu_pkg::err_none;
  endfunction

  function automatic void add_instr(input logic [7:0] op, input int cnt, input int base,
                                    input cpu_pkg::word_t val);
    prog.push_back({op, 3'(cnt), 5'(base)});  // opcode | count-1 | base
    prog.push_back(val);
  endfunction

  // one host write, entered and left 2 ns after a rising edge
  task automatic host_write(input cpu_pkg::word_t a, input cpu_pkg::word_t d);
    host_we    = 1'b1;
    host_addr  = a;
    host_wdata = d;
    model_mem[a] = d;
    @(posedge clk);
    #2;
    host_we = 1'b0;
  endtask

  task automatic load_program();
    foreach (prog[i]) host_write(16'(cpu_pkg::address_program + i), prog[i]);
    prog.delete();
  endtask

  // poke: host write and a second start in the middle of the run
  task automatic run_program(input bit poke);
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
    assert (busy === 1'b1) else begin
      status_errors++;
      $display("CHECK FAILED at %0t: busy is %b after start, expected 1", $time, busy);
    end
    if (poke) begin
      repeat (10) @(posedge clk);
      #2;
      host_we    = 1'b1;
      host_addr  = 16'd460;
      host_wdata = 16'hdead;
      start      = 1'b1;
      @(posedge clk);
      #2;
      host_we = 1'b0;
      start   = 1'b0;
    end
    wait (halted);
    @(posedge clk);
    #2;
    assert (busy === 1'b0) else begin
      status_errors++;
      $display("CHECK FAILED at %0t: busy is %b after halt, expected 0", $time, busy);
    end
  endtask

  task automatic run_test(input bit poke);
    load_program();
    exp_err = run_model();
    run_program(poke);
    cmp_req++;
    wait (cmp_done == cmp_req);  // read-back finished
    @(posedge clk);
    #2;
  endtask

  task automatic random_program();
    int         n_instr;
    int         cnt;
    int         base;
    logic [7:0] op;
    cpu_pkg::word_t val;
    n_instr = 3 + int'($unsigned($random(seed)) % 6);
    repeat (n_instr) begin
      cnt  = int'($unsigned($random(seed)) % 8);
      base = int'($unsigned($random(seed)) % (32 - cnt));  // always a legal group
      val  = 16'($random(seed));
      case (int'($unsigned($random(seed)) % 6))
        0: op = cpu_pkg::op_num2reg;
        1: op = cpu_pkg::op_reg_plus;
        2: op = cpu_pkg::op_reg_minus;
        3: op = cpu_pkg::op_reg_mul;
        4: op = cpu_pkg::op_ram2reg;
        default: op = cpu_pkg::op_reg2ram;
      endcase
      if (op == cpu_pkg::op_ram2reg || op == cpu_pkg::op_reg2ram)
        val = 16'(view_lo + int'($unsigned($random(seed)) % 57));  // block stays in view
      add_instr(op, cnt, base, val);
    end
    add_instr(cpu_pkg::op_exit, 0, 0, 16'd0);
  endtask

  initial begin : compare_proc
    forever begin
      wait (cmp_req != cmp_done);
      for (int a = view_base; a < cpu_pkg::ram_words; a++) begin
        if (a < cpu_pkg::address_program || (a >= view_lo && a < view_mid) ||
            a >= view_top) begin
          @(posedge clk);
          #2;
          cmp_addr = 16'(a);
          @(negedge clk);  // async read settled long before
          assert (host_rdata === model_mem[a]) else begin
            mem_errors++;
            $display("CHECK FAILED at %0t: word %0d is %h, expected %h",
                     $time, a, host_rdata, model_mem[a]);
          end
        end
      end
      assert (error_code === exp_err) else begin
        code_errors++;
        $display("CHECK FAILED at %0t: error_code %0d, expected %0d",
                 $time, error_code, exp_err);
      end
      cmp_done = cmp_req;
    end
  end

  initial begin : watchdog
    #(timeout_ns);
    $display("timeout: no result after %0d ns, the machine never halted", timeout_ns);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main_seq
    rst        = 1'b1;
    start      = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int a = 0; a < cpu_pkg::ram_words; a++) host_write(16'(a), 16'(a * 37) ^ 16'h5a3c);

    add_instr(cpu_pkg::op_num2reg, 3, 4, 16'h1234);  // four equal values
    add_instr(cpu_pkg::op_reg2ram, 3, 4, 16'd410);
    add_instr(cpu_pkg::op_exit, 0, 0, 16'd0);
    run_test(1'b0);

    add_instr(cpu_pkg::op_num2reg, 3, 8, 16'hfff0);
    add_instr(cpu_pkg::op_reg_plus, 3, 8, 16'h0020);   // wraps to 0x0010
    add_instr(cpu_pkg::op_reg_minus, 1, 9, 16'h0030);  // wraps below zero
    add_instr(cpu_pkg::op_reg_mul, 1, 10, 16'h1001);
    add_instr(cpu_pkg::op_reg2ram, 3, 8, 16'd420);
    add_instr(cpu_pkg::op_exit, 0, 0, 16'd0);
    run_test(1'b0);

    for (int i = 0; i < 6; i++) host_write(16'(430 + i), 16'($random(seed)));
    add_instr(cpu_pkg::op_ram2reg, 5, 12, 16'd430);
    add_instr(cpu_pkg::op_reg2ram, 5, 12, 16'd440);
    add_instr(cpu_pkg::op_ram2reg, 5, 0, 16'd440);   // reads the block stored just before
    add_instr(cpu_pkg::op_reg2ram, 5, 0, 16'd450);
    add_instr(cpu_pkg::op_exit, 0, 0, 16'd0);
    run_test(1'b0);

    add_instr(cpu_pkg::op_reg2ram, 3, 30, 16'd400);  // r30..r33
    add_instr(cpu_pkg::op_exit, 0, 0, 16'd0);
    run_test(1'b0);
    add_instr(cpu_pkg::op_reg2ram, 0, 0, 16'd40);    // below the program area
    add_instr(cpu_pkg::op_exit, 0, 0, 16'd0);
    run_test(1'b0);
    add_instr(cpu_pkg::op_reg2ram, 7, 0, 16'd694);   // last word would be 701
    add_instr(cpu_pkg::op_exit, 0, 0, 16'd0);
    run_test(1'b0);
    add_instr(8'h0c, 0, 0, 16'd400);
    add_instr(cpu_pkg::op_exit, 0, 0, 16'd0);
    run_test(1'b0);

    repeat (20) begin
      random_program();
      run_test(1'b0);
    end

    add_instr(cpu_pkg::op_reg_plus, 7, 20, 16'd7);   // a restart would add twice
    add_instr(cpu_pkg::op_reg2ram, 7, 20, 16'd400);
    add_instr(cpu_pkg::op_exit, 0, 0, 16'd0);
    run_test(1'b1);

    $display("mismatched words: %0d, wrong error codes: %0d, wrong busy levels: %0d",
             mem_errors, code_errors, status_errors);
    if (mem_errors + code_errors + status_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: reg_cpu.f
cpu_pkg.sv
instr_if.sv
program_ram.sv
seq_ctrl.sv
instr_check.sv
exec_unit.sv
retire_unit.sv
reg_cpu.sv
reg_cpu_chk.sv
reg_cpu_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ps -f reg_cpu.f \
  --top-module reg_cpu_tb -o reg_cpu_tb &&
./obj_dir/reg_cpu_tb | tee /dev/stderr | grep -q "Result: PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
